// File: src/trvk_macros.svh
/* fixed map geometry; one map bit per 8-byte heap granule
   the heap base must be 8-byte aligned */
`ifndef TRVK_MACROS_SVH
`define TRVK_MACROS_SVH

// first byte covered by the revocation map
`define TRVK_HEAP_BASE 32'h8000_0000

// map depth in 32-bit words and the matching address width
`define TRVK_TSMAP_WORDS 2048
`define TRVK_MAP_AW 11

// bit index within a map word, register file index
`define TRVK_BIT_W 5
`define TRVK_REG_AW 5

`endif

// File: src/cap_pkg.sv
/* simplified capability metadata, not the full CHERI bounds encoding
   exp is clamped to 22 so that the base field still fits below bit 32 */
package cap_pkg;

  // largest exponent the base recovery accepts
  localparam int unsigned CAP_EXP_MAX = 22;

  // metadata as it comes back with a capability load
  typedef struct packed {
    logic       valid;
    logic [4:0] exp;
    logic [8:0] base;
    // signed correction, only -1, 0 and +1 are legal
    logic [1:0] base_cor;
  } reg_cap_t;

  localparam reg_cap_t NULL_REG_CAP = '{
    valid:    1'b0,
    exp:      5'd0,
    base:     9'd0,
    base_cor: 2'd0
  };

  // rebuild the 32-bit base from the metadata and the address word
  function automatic logic [31:0] get_base32(reg_cap_t cap, logic [31:0] addr);
    logic [4:0]  exp;
    logic [5:0]  top_sh;
    logic [31:0] top;
    logic [31:0] cor;
    exp    = (cap.exp > CAP_EXP_MAX) ? 5'(CAP_EXP_MAX) : cap.exp;
    top_sh = 6'(exp) + 6'd9;
    // address bits above the base field
    top    = addr >> top_sh;
    cor    = {{30{cap.base_cor[1]}}, cap.base_cor};
    top    = top + cor;
    // corrected upper bits, then the base field at exp, zeros below
    return (top << top_sh) | (32'(cap.base) << exp);
  endfunction

endpackage

// File: src/trvk_pkg.sv
/* types shared by the revocation check pipeline */
`include "trvk_macros.svh"

package trvk_pkg;

  // which client a load response belongs to
  typedef enum logic [1:0] {
    SRC_NONE  = 2'd0,
    SRC_CPU   = 2'd1,
    SRC_SWEEP = 2'd2
  } trvk_src_e;

  typedef logic [`TRVK_MAP_AW-1:0] map_addr_t;
  typedef logic [`TRVK_BIT_W-1:0]  bit_pos_t;
  typedef logic [`TRVK_REG_AW-1:0] reg_addr_t;

endpackage

// File: src/trvk_ctrl.sv
/* fixed three-clock pipeline with no stall; CPU and sweeper share one
   response bus, so at most one of them may respond per cycle (CPU wins) */
`timescale 1ns/1ps

module trvk_ctrl (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rf_trsv_en_i,
  input  trvk_pkg::reg_addr_t rf_trsv_addr_i,
  input  logic                lsu_resp_valid_i,
  input  logic                lsu_load_err_i,
  input  logic                lsu_cap_tag_i,
  input  logic                lsu_resp_is_wr_i,
  input  logic                sweep_resp_valid_i,
  input  logic                sweep_resp_err_i,
  input  logic                range_ok_i,
  input  trvk_pkg::bit_pos_t  bit_pos_i,
  input  logic [31:0]         map_rdata_i,
  output logic                cap_load_o,
  output logic                map_cs_o,
  output logic                rf_trvk_en_o,
  output trvk_pkg::reg_addr_t rf_trvk_addr_o,
  output logic                rf_trvk_clrtag_o,
  output logic                sweep_trvk_en_o,
  output logic                sweep_trvk_clrtag_o
);

  import trvk_pkg::*;

  // reservation state
  logic      cpu_active_q;
  reg_addr_t trsv_addr_q;

  // response qualification
  trvk_src_e op_src;
  logic      op_err;
  logic      cap_good;

  // per-stage control
  logic [2:0] cpu_vld_q;
  logic [2:0] sweep_vld_q;
  logic [2:0] cap_good_q;
  logic [2:1] range_ok_q;
  reg_addr_t  rd_addr_q [3];
  bit_pos_t   bit_pos_q;
  logic       revoke_q;
  logic       clrtag;

  // a CPU response only counts while a reservation is open
  always_comb begin
    if (cpu_active_q && lsu_resp_valid_i) begin
      op_src = SRC_CPU;
    end else if (sweep_resp_valid_i && !lsu_resp_is_wr_i) begin
      op_src = SRC_SWEEP;
    end else begin
      op_src = SRC_NONE;
    end
  end

  assign op_err     = (op_src == SRC_CPU) ? lsu_load_err_i : sweep_resp_err_i;
  assign cap_load_o = (op_src != SRC_NONE) && !op_err;
  assign cap_good   = cap_load_o && lsu_cap_tag_i;

  // only look up the map for a tagged capability
  assign map_cs_o = (cpu_vld_q[0] | sweep_vld_q[0]) & cap_good_q[0];

  assign clrtag = revoke_q & cap_good_q[2] & range_ok_q[2];

  // reservation tracking, a new pulse wins over a closing response
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cpu_active_q <= 1'b0;
    end else if (rf_trsv_en_i) begin
      cpu_active_q <= 1'b1;
    end else if (lsu_resp_valid_i) begin
      cpu_active_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rf_trsv_en_i) begin
      trsv_addr_q <= rf_trsv_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cpu_vld_q           <= '0;
      sweep_vld_q         <= '0;
      cap_good_q          <= '0;
      rf_trvk_en_o        <= 1'b0;
      sweep_trvk_en_o     <= 1'b0;
      rf_trvk_clrtag_o    <= 1'b0;
      sweep_trvk_clrtag_o <= 1'b0;
    end else begin
      cpu_vld_q           <= {cpu_vld_q[1:0], op_src == SRC_CPU};
      sweep_vld_q         <= {sweep_vld_q[1:0], op_src == SRC_SWEEP};
      cap_good_q          <= {cap_good_q[1:0], cap_good};
      // results leave one clock after stage 2
      rf_trvk_en_o        <= cpu_vld_q[2];
      sweep_trvk_en_o     <= sweep_vld_q[2];
      rf_trvk_clrtag_o    <= clrtag;
      sweep_trvk_clrtag_o <= clrtag;
    end
  end

  // datapath stages
  always_ff @(posedge clk_i) begin
    rd_addr_q[0]   <= trsv_addr_q;
    rd_addr_q[1]   <= rd_addr_q[0];
    rd_addr_q[2]   <= rd_addr_q[1];
    rf_trvk_addr_o <= rd_addr_q[2];
    // decoder results are valid in stage 0
    bit_pos_q      <= bit_pos_i;
    range_ok_q[1]  <= range_ok_i;
    // map word arrives in stage 1
    range_ok_q[2]  <= range_ok_q[1];
    revoke_q       <= map_rdata_i[bit_pos_q];
  end

endmodule

// File: src/cap_base_decode.sv
/* base decode for the map lookup; results are combinational in stage 0
   and hold the last captured capability when no load is strobed */
`timescale 1ns/1ps
`include "trvk_macros.svh"

module cap_base_decode (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                cap_load_i,
  input  cap_pkg::reg_cap_t   lsu_rcap_i,
  input  logic [31:0]         lsu_rdata_i,
  output trvk_pkg::map_addr_t map_addr_o,
  output trvk_pkg::bit_pos_t  bit_pos_o,
  output logic                range_ok_o
);

  import cap_pkg::*;
  import trvk_pkg::*;

  reg_cap_t    cap_q;
  logic [31:0] addr_q;
  logic [31:0] base32;
  logic [31:0] granule;

  // hold the loaded capability for the lookup
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cap_q  <= NULL_REG_CAP;
      addr_q <= 32'h0;
    end else if (cap_load_i) begin
      cap_q  <= lsu_rcap_i;
      addr_q <= lsu_rdata_i;
    end
  end

  assign base32 = get_base32(cap_q, addr_q);

  // granule index relative to the heap, below-heap bases wrap high
  assign granule = (base32 - `TRVK_HEAP_BASE) >> 3;

  assign map_addr_o = granule[`TRVK_MAP_AW+4:5];
  assign bit_pos_o  = granule[4:0];
  assign range_ok_o = (granule[31:5] < `TRVK_TSMAP_WORDS);

endmodule

// File: src/tsmap_ram.sv
/* contents are not reset, every word must be written before use
   a read colliding with a write returns the old word */
`timescale 1ns/1ps
`include "trvk_macros.svh"

module tsmap_ram (
  input  logic                clk_i,
  input  logic                map_cs_i,
  input  trvk_pkg::map_addr_t map_raddr_i,
  input  logic                map_we_i,
  input  trvk_pkg::map_addr_t map_waddr_i,
  input  logic [31:0]         map_wdata_i,
  output logic [31:0]         map_rdata_o
);

  import trvk_pkg::*;

  // one bit per freed granule
  logic [31:0] mem_q [`TRVK_TSMAP_WORDS];

  // allocator write port
  always_ff @(posedge clk_i) begin
    if (map_we_i) begin
      mem_q[map_waddr_i] <= map_wdata_i;
    end
  end

  // registered read, only on chip select
  always_ff @(posedge clk_i) begin
    if (map_cs_i) begin
      map_rdata_o <= mem_q[map_raddr_i];
    end
  end

endmodule

// File: src/trvk_top.sv
/* revocation check top; results appear three clocks after a response
   the map must be filled through the write port before use */
`timescale 1ns/1ps

module trvk_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                rf_trsv_en_i,
  input  trvk_pkg::reg_addr_t rf_trsv_addr_i,
  input  logic                lsu_resp_valid_i,
  input  logic                lsu_load_err_i,
  input  cap_pkg::reg_cap_t   lsu_rcap_i,
  input  logic [31:0]         lsu_rdata_i,
  input  logic                lsu_resp_is_wr_i,
  input  logic                sweep_resp_valid_i,
  input  logic                sweep_resp_err_i,
  input  logic                map_we_i,
  input  trvk_pkg::map_addr_t map_waddr_i,
  input  logic [31:0]         map_wdata_i,
  output logic                rf_trvk_en_o,
  output trvk_pkg::reg_addr_t rf_trvk_addr_o,
  output logic                rf_trvk_clrtag_o,
  output logic                sweep_trvk_en_o,
  output logic                sweep_trvk_clrtag_o
);

  import trvk_pkg::*;

  logic        cap_load;
  logic        map_cs;
  map_addr_t   map_addr;
  bit_pos_t    bit_pos;
  logic        range_ok;
  logic [31:0] map_rdata;

  trvk_ctrl i_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .rf_trsv_en_i        (rf_trsv_en_i),
    .rf_trsv_addr_i      (rf_trsv_addr_i),
    .lsu_resp_valid_i    (lsu_resp_valid_i),
    .lsu_load_err_i      (lsu_load_err_i),
    .lsu_cap_tag_i       (lsu_rcap_i.valid),
    .lsu_resp_is_wr_i    (lsu_resp_is_wr_i),
    .sweep_resp_valid_i  (sweep_resp_valid_i),
    .sweep_resp_err_i    (sweep_resp_err_i),
    .range_ok_i          (range_ok),
    .bit_pos_i           (bit_pos),
    .map_rdata_i         (map_rdata),
    .cap_load_o          (cap_load),
    .map_cs_o            (map_cs),
    .rf_trvk_en_o        (rf_trvk_en_o),
    .rf_trvk_addr_o      (rf_trvk_addr_o),
    .rf_trvk_clrtag_o    (rf_trvk_clrtag_o),
    .sweep_trvk_en_o     (sweep_trvk_en_o),
    .sweep_trvk_clrtag_o (sweep_trvk_clrtag_o)
  );

  cap_base_decode i_decode (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .cap_load_i  (cap_load),
    .lsu_rcap_i  (lsu_rcap_i),
    .lsu_rdata_i (lsu_rdata_i),
    .map_addr_o  (map_addr),
    .bit_pos_o   (bit_pos),
    .range_ok_o  (range_ok)
  );

  tsmap_ram i_tsmap (
    .clk_i       (clk_i),
    .map_cs_i    (map_cs),
    .map_raddr_i (map_addr),
    .map_we_i    (map_we_i),
    .map_waddr_i (map_waddr_i),
    .map_wdata_i (map_wdata_i),
    .map_rdata_o (map_rdata)
  );

endmodule

// File: sim/tb_trvk.sv
/* self-checking testbench for trvk_top; every result is expected exactly
   three clocks after its response is sampled, the map is filled first */
`timescale 1ns/1ps
`include "trvk_macros.svh"

module tb_trvk;

  import cap_pkg::*;
  import trvk_pkg::*;

  typedef struct {
    int        issue;
    logic      cpu;
    logic      sweep;
    reg_addr_t addr;
    logic      clrtag;
  } result_t;

  logic        clk_i, rst_ni;
  logic        rf_trsv_en_i, lsu_resp_valid_i, lsu_load_err_i, lsu_resp_is_wr_i;
  logic        sweep_resp_valid_i, sweep_resp_err_i, map_we_i;
  reg_addr_t   rf_trsv_addr_i, rf_trvk_addr_o;
  reg_cap_t    lsu_rcap_i;
  logic [31:0] lsu_rdata_i, map_wdata_i;
  map_addr_t   map_waddr_i;
  logic        rf_trvk_en_o, rf_trvk_clrtag_o, sweep_trvk_en_o, sweep_trvk_clrtag_o;

  // stimulus for the next clock, applied by tick
  logic        n_trsv_en, n_cpu_vld, n_load_err, n_is_wr, n_sweep_vld, n_sweep_err, n_we;
  reg_addr_t   n_trsv_addr;
  reg_cap_t    n_cap;
  logic [31:0] n_rdata, n_wdata;
  map_addr_t   n_waddr;

  // reference state
  logic [31:0] shadow [`TRVK_TSMAP_WORDS];
  result_t     exp_q [$];
  logic        rsv_active;
  reg_addr_t   rsv_addr;
  int          cyc;
  string       test_name;

  trvk_top i_dut (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
  end

  // base recovery following the capability format rule
  function automatic logic [31:0] expected_base(reg_cap_t cap, logic [31:0] addr);
    int unsigned sh;
    logic [31:0] upper;
    sh    = cap.exp + 9;
    upper = addr >> sh;
    if (cap.base_cor == 2'b01) begin
      upper = upper + 32'd1;
    end else if (cap.base_cor == 2'b11) begin
      upper = upper - 32'd1;
    end
    return (upper << sh) | ({23'd0, cap.base} << cap.exp);
  endfunction

  // clear-tag decision against the shadow map, out of range never clears
  function automatic logic expected_clrtag(logic good, reg_cap_t cap, logic [31:0] addr);
    logic [31:0] ptr;
    ptr = (expected_base(cap, addr) - `TRVK_HEAP_BASE) >> 3;
    if (!good || (ptr >> 5) >= `TRVK_TSMAP_WORDS) begin
      return 1'b0;
    end
    return shadow[ptr >> 5][ptr[4:0]];
  endfunction

  function automatic logic [31:0] granule_byte(int unsigned w, int unsigned b);
    return `TRVK_HEAP_BASE + ((w * 32 + b) << 3);
  endfunction

  function automatic logic [1:0] cor_pick();
    case ($urandom % 3)
      0:       return 2'b11;
      1:       return 2'b00;
      default: return 2'b01;
    endcase
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Fail %s/%s: expected %0h, actual %0h",
                          test_name, name, expected, actual));
    end
  endtask

  task automatic set_idle();
    n_trsv_en   = 1'b0;
    n_trsv_addr = '0;
    n_cpu_vld   = 1'b0;
    n_load_err  = 1'b0;
    n_is_wr     = 1'b0;
    n_sweep_vld = 1'b0;
    n_sweep_err = 1'b0;
    n_we        = 1'b0;
    n_waddr     = '0;
    n_wdata     = '0;
    n_cap       = '0;
    n_rdata     = '0;
  endtask

  // drive one clock of stimulus and queue what it must produce
  task automatic tick();
    result_t r;
    logic    cpu_op;
    logic    sweep_op;
    @(posedge clk_i);
    rf_trsv_en_i       <= n_trsv_en;
    rf_trsv_addr_i     <= n_trsv_addr;
    lsu_resp_valid_i   <= n_cpu_vld;
    lsu_load_err_i     <= n_load_err;
    lsu_rcap_i         <= n_cap;
    lsu_rdata_i        <= n_rdata;
    lsu_resp_is_wr_i   <= n_is_wr;
    sweep_resp_valid_i <= n_sweep_vld;
    sweep_resp_err_i   <= n_sweep_err;
    map_we_i           <= n_we;
    map_waddr_i        <= n_waddr;
    map_wdata_i        <= n_wdata;
    // the write lands one clock before the lookup reads the map
    if (n_we) begin
      shadow[n_waddr] = n_wdata;
    end
    cpu_op   = rsv_active && n_cpu_vld;
    sweep_op = !cpu_op && n_sweep_vld && !n_is_wr;
    if (cpu_op || sweep_op) begin
      r.issue  = cyc + 2;
      r.cpu    = cpu_op;
      r.sweep  = sweep_op;
      r.addr   = rsv_addr;
      r.clrtag = expected_clrtag(!(cpu_op ? n_load_err : n_sweep_err) && n_cap.valid,
                                 n_cap, n_rdata);
      exp_q.push_back(r);
    end
    if (n_trsv_en) begin
      rsv_active = 1'b1;
      rsv_addr   = n_trsv_addr;
    end else if (n_cpu_vld) begin
      rsv_active = 1'b0;
    end
    set_idle();
  endtask

  // capability with exp 3 whose recovered base is byte address b
  task automatic aim(logic [31:0] b, logic [1:0] cor, logic tag);
    n_cap.valid    = tag;
    n_cap.exp      = 5'd3;
    n_cap.base     = b[11:3];
    n_cap.base_cor = cor;
    n_rdata        = (cor == 2'b01) ? b - 32'h1000 : (cor == 2'b11) ? b + 32'h1000 : b;
  endtask

  task automatic random_cap();
    if ($urandom % 2) begin
      aim(granule_byte($urandom % 1024, $urandom % 32), cor_pick(), ($urandom % 8) != 0);
    end else begin
      n_cap.valid    = ($urandom % 8) != 0;
      n_cap.exp      = 5'($urandom % 23);
      n_cap.base     = 9'($urandom);
      n_cap.base_cor = cor_pick();
      n_rdata        = `TRVK_HEAP_BASE + ($urandom % 32'h40000) - 32'h100;
    end
  endtask

  task automatic cpu_resp(logic err);
    n_cpu_vld  = 1'b1;
    n_load_err = err;
    tick();
  endtask

  task automatic sweep_resp(logic err, logic wr);
    n_sweep_vld = 1'b1;
    n_sweep_err = err;
    n_is_wr     = wr;
    tick();
  endtask

  task automatic write_word(map_addr_t w, logic [31:0] d);
    n_we    = 1'b1;
    n_waddr = w;
    n_wdata = d;
    tick();
  endtask

  task automatic reserve(reg_addr_t a);
    n_trsv_en   = 1'b1;
    n_trsv_addr = a;
    tick();
  endtask

  task automatic idle(int n);
    repeat (n) tick();
  endtask

  // outputs seen mid-cycle against the queued expectations
  always @(negedge clk_i) begin : compare
    result_t e;
    if (rst_ni) begin
      e = '{issue: 0, cpu: 1'b0, sweep: 1'b0, addr: '0, clrtag: 1'b0};
      if (exp_q.size() > 0 && exp_q[0].issue == cyc - 3) begin
        e = exp_q.pop_front();
      end
      check_value("rf_trvk_en", e.cpu, rf_trvk_en_o);
      check_value("sweep_trvk_en", e.sweep, sweep_trvk_en_o);
      check_value("rf_trvk_clrtag", e.clrtag, rf_trvk_clrtag_o);
      check_value("sweep_trvk_clrtag", e.clrtag, sweep_trvk_clrtag_o);
      if (e.cpu) begin
        check_value("rf_trvk_addr", e.addr, rf_trvk_addr_o);
      end
    end
  end

  initial begin
    int kind;
    int waited;
    void'($urandom(32'h3feaca5c));
    clk_i      = 1'b0;
    rst_ni     = 1'b0;
    cyc        = 0;
    rsv_active = 1'b0;
    rsv_addr   = '0;
    test_name  = "reset";
    set_idle();
    rf_trsv_en_i       = 1'b0;
    rf_trsv_addr_i     = '0;
    lsu_resp_valid_i   = 1'b0;
    lsu_load_err_i     = 1'b0;
    lsu_rcap_i         = '0;
    lsu_rdata_i        = '0;
    lsu_resp_is_wr_i   = 1'b0;
    sweep_resp_valid_i = 1'b0;
    sweep_resp_err_i   = 1'b0;
    map_we_i           = 1'b0;
    map_waddr_i        = '0;
    map_wdata_i        = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;
    idle(6);

    test_name = "map_fill";
    for (int w = 0; w < `TRVK_TSMAP_WORDS; w++) begin
      write_word(w, $urandom);
    end

    test_name = "cpu_load";
    write_word(10, 32'h0000_00f1);
    reserve(5'd3);
    aim(granule_byte(10, 0), 2'b00, 1'b1);
    cpu_resp(1'b0);
    reserve(5'd17);
    aim(granule_byte(10, 1), 2'b11, 1'b1);
    cpu_resp(1'b0);
    reserve(5'd22);
    aim(granule_byte(10, 4), 2'b01, 1'b1);
    cpu_resp(1'b0);
    // new reservation in the same cycle as the closing response
    reserve(5'd7);
    n_trsv_en   = 1'b1;
    n_trsv_addr = 5'd9;
    aim(granule_byte(10, 5), 2'b00, 1'b1);
    cpu_resp(1'b0);
    aim(granule_byte(10, 6), 2'b00, 1'b1);
    cpu_resp(1'b0);
    idle(4);

    test_name = "sweep";
    write_word(20, 32'h8000_0001);
    aim(granule_byte(20, 31), 2'b00, 1'b1);
    sweep_resp(1'b0, 1'b0);
    aim(granule_byte(20, 30), 2'b01, 1'b1);
    sweep_resp(1'b0, 1'b0);
    aim(granule_byte(20, 0), 2'b00, 1'b1);
    sweep_resp(1'b0, 1'b1);
    idle(4);

    test_name = "tag_and_errors";
    reserve(5'd12);
    aim(granule_byte(10, 0), 2'b00, 1'b0);
    cpu_resp(1'b0);
    reserve(5'd13);
    aim(granule_byte(10, 0), 2'b00, 1'b1);
    cpu_resp(1'b1);
    aim(granule_byte(20, 31), 2'b00, 1'b1);
    sweep_resp(1'b1, 1'b0);
    idle(4);

    test_name = "out_of_range";
    write_word(0, 32'hffff_ffff);
    write_word(`TRVK_TSMAP_WORDS - 1, 32'hffff_ffff);
    reserve(5'd30);
    aim(`TRVK_HEAP_BASE - 32'd8, 2'b00, 1'b1);
    cpu_resp(1'b0);
    aim(`TRVK_HEAP_BASE + 32'h8_0000, 2'b00, 1'b1);
    sweep_resp(1'b0, 1'b0);
    aim(granule_byte(0, 5), 2'b00, 1'b1);
    sweep_resp(1'b0, 1'b0);
    idle(4);

    test_name = "random_mix";
    for (int i = 0; i < 400; i++) begin
      kind = $urandom % 4;
      if ($urandom % 3 == 0) begin
        n_trsv_en   = 1'b1;
        n_trsv_addr = 5'($urandom);
      end
      // map writes go to the upper half, lookups mostly aim low
      if ($urandom % 2 == 0) begin
        n_we    = 1'b1;
        n_waddr = 11'h400 + 11'($urandom % 1024);
        n_wdata = $urandom;
      end
      random_cap();
      case (kind)
        1: begin
          n_cpu_vld  = 1'b1;
          n_load_err = ($urandom % 8) == 0;
        end
        2: begin
          n_sweep_vld = 1'b1;
          n_sweep_err = ($urandom % 8) == 0;
        end
        3: begin
          n_sweep_vld = 1'b1;
          n_is_wr     = 1'b1;
        end
        default: ;
      endcase
      tick();
    end

    test_name = "drain";
    waited    = 0;
    while (exp_q.size() > 0) begin
      if (waited == 20) begin
        abort_run("results still outstanding 20 cycles after the last response");
      end else begin
        tick();
        waited++;
      end
    end
    idle(4);
    $display("=== PASS ===");
    $finish;
  end

endmodule

// File: list.f
+incdir+src
src/cap_pkg.sv
src/trvk_pkg.sv
src/trvk_ctrl.sv
src/cap_base_decode.sv
src/tsmap_ram.sv
src/trvk_top.sv
sim/tb_trvk.sv

// File: Bender.yml
package:
  name: trvk

sources:
  - include_dirs:
      - src
    files:
      - src/cap_pkg.sv
      - src/trvk_pkg.sv
      - src/trvk_ctrl.sv
      - src/cap_base_decode.sv
      - src/tsmap_ram.sv
      - src/trvk_top.sv
  - target: simulation
    include_dirs:
      - src
    files:
      - sim/tb_trvk.sv
